// ==== Makefile ====
# Verilator build and run for the two-wide RV32I core
VERILATOR ?= verilator
TOP       ?= rv32_dual_tb
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
SIM_DIR   ?= sim
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SOURCES := $(wildcard source/*.sv sim/*.sv)
BINARY  := $(BUILD_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, and search $(LOG) for the pass line"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "Overridable: VERILATOR TOP FLIST BUILD_DIR SIM_DIR LOG VFLAGS"

$(BINARY): $(FLIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FLIST)

# The memory loads program.hex from the working directory
test: $(BINARY)
	cd $(SIM_DIR) && $(CURDIR)/$(BINARY) > $(CURDIR)/$(LOG) 2>&1; true
	@cat $(LOG)
	@grep -q "^PASS: all tests$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== flist.f ====
source/rv32_pkg.sv
source/lane_ifs.sv
source/alu.sv
source/fetch_pair.sv
source/exec_lane.sv
source/register_file.sv
source/unified_memory.sv
source/rv32_dual_top.sv
sim/tb_clock_gen.sv
sim/rv32_dual_assertions.sv
sim/rv32_dual_tb.sv

// ==== sim/program.hex ====
// One instruction per line as four bytes, least significant byte first
// @ lines give the byte address; x1 holds the UART address 0xfff0
@0
B7 00 01 00  // 00 lui  x1, 0x10
93 80 00 FF  // 04 addi x1, x1, -16
13 01 50 00  // 08 addi x2, x0, 5
93 01 70 00  // 0c addi x3, x0, 7
33 02 31 00  // 10 add  x4, x2, x3
23 80 40 00  // 14 sb   x4, 0(x1)
93 02 40 01  // 18 addi x5, x0, 20
13 83 A2 FF  // 1c addi x6, x5, -6
23 80 60 00  // 20 sb   x6, 0(x1)
93 03 30 00  // 24 addi x7, x0, 3
13 94 43 00  // 28 slli x8, x7, 4
23 80 80 00  // 2c sb   x8, 0(x1)
93 04 F0 FF  // 30 addi x9, x0, -1
13 05 10 00  // 34 addi x10, x0, 1
B3 A5 A4 00  // 38 slt  x11, x9, x10
23 80 B0 00  // 3c sb   x11, 0(x1)
13 06 00 08  // 40 addi x12, x0, 0x80
93 06 00 20  // 44 addi x13, x0, 0x200
23 80 C6 00  // 48 sb   x12, 0(x13)
13 0A 50 05  // 4c addi x20, x0, 0x55
03 87 06 00  // 50 lb   x14, 0(x13)
83 C7 06 00  // 54 lbu  x15, 0(x13)
23 80 E0 00  // 58 sb   x14, 0(x1)
13 58 F7 01  // 5c srli x16, x14, 31
23 80 F0 00  // 60 sb   x15, 0(x1)
93 08 10 00  // 64 addi x17, x0, 1
23 80 00 01  // 68 sb   x16, 0(x1)
13 09 E0 0E  // 6c addi x18, x0, 0xee
63 88 18 01  // 70 beq  x17, x17, +16
23 80 20 01  // 74 sb   x18, 0(x1)   squashed slot
23 80 20 01  // 78 sb   x18, 0(x1)   fall-through
23 80 20 01  // 7c sb   x18, 0(x1)   fall-through
23 80 40 01  // 80 sb   x20, 0(x1)
6F 00 C0 07  // 84 jal  x0, +0x7c
@100
6F 00 00 00  // 100 jal x0, 0
00 00 00 00  // 104 padding

// ==== sim/rv32_dual_assertions.sv ====
////////////////////////////////////////////////////////////
// Concurrent checks on pc alignment, UART strobe and x0
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module rv32_dual_assertions import rv32_pkg::*; (
  input logic                  clock,
  input logic                  reset_n,
  input logic [xlen-1:0]       pc,
  input logic                  uart_valid,
  input logic                  store_en1,
  input logic [xlen-1:0]       addr1,
  input logic                  store_en2,
  input logic [xlen-1:0]       addr2,
  input logic [reg_addr_w-1:0] rs1_addr1,
  input logic [xlen-1:0]       rs1_data1,
  input logic [reg_addr_w-1:0] rs1_addr2,
  input logic [xlen-1:0]       rs1_data2
);

  logic uart_store;

  assign uart_store = (store_en1 && (addr1 == uart_addr)) ||
                      (store_en2 && (addr2 == uart_addr));

  // Each strobe cycle follows its own UART store
  a_uart_strobe: assert property (@(posedge clock) disable iff (!reset_n)
    uart_valid |-> $past(uart_store))
    else $error("uart_valid high without a UART store on the previous edge");

  a_pc_aligned: assert property (@(posedge clock) disable iff (!reset_n)
    pc[1:0] == 2'b00)
    else $error("fetch pc not word aligned");

  a_x0_lane1: assert property (@(posedge clock) disable iff (!reset_n)
    (rs1_addr1 == '0) |-> (rs1_data1 == '0))
    else $error("lane 1 read a nonzero x0");

  a_x0_lane2: assert property (@(posedge clock) disable iff (!reset_n)
    (rs1_addr2 == '0) |-> (rs1_data2 == '0))
    else $error("lane 2 read a nonzero x0");

endmodule

bind rv32_dual_top rv32_dual_assertions u_assertions (
  .clock      (clock),
  .reset_n    (reset_n),
  .pc         (pc_out),
  .uart_valid (uart_valid),
  .store_en1  (mp1.store_en),
  .addr1      (mp1.addr),
  .store_en2  (mp2.store_en),
  .addr2      (mp2.addr),
  .rs1_addr1  (rp1.rs1_addr),
  .rs1_data1  (rp1.rs1_data),
  .rs1_addr2  (rp2.rs1_addr),
  .rs1_data2  (rp2.rs1_data)
);

`default_nettype wire

// ==== sim/rv32_dual_tb.sv ====
////////////////////////////////////////////////////////////
// Testbench: reset checks, expected UART byte table, halt
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module rv32_dual_tb import rv32_pkg::*; ();

  localparam int num_entries     = 8;
  localparam int cycles_per_byte = 200;
  localparam int idle_cycles     = 20;
  localparam int reset_cycles    = 8;
  localparam int timeout_cycles  = reset_cycles + num_entries * cycles_per_byte + idle_cycles;

  localparam logic [xlen-1:0] halt_pc   = 32'h0000_0100;  // Final self-loop
  localparam logic [xlen-1:0] lb_value  = 32'($signed(8'h80));
  localparam logic [xlen-1:0] lbu_value = 32'(8'h80);

  logic            clock;
  logic            reset_n;
  logic [xlen-1:0] pc_out;
  logic            uart_valid;
  logic [7:0]      uart_data;

  // Expected UART bytes in program order
  logic [7:0] exp_byte [num_entries] = '{
    8'(5 + 7),
    8'(20 - 6),
    8'(3 << 4),
    8'(-32'sd1 < 32'sd1),
    lb_value[7:0],
    lbu_value[7:0],
    8'(lb_value[31]),     // Only set when lb sign-extends
    8'h55                 // Marker at the beq target, 0xee must not show up
  };

  string exp_origin [num_entries] = '{
    "5 + 7",
    "20 - 6",
    "3 << 4",
    "slt -1, 1",
    "lb of 0x80",
    "lbu of 0x80",
    "bit 31 of lb",
    "marker at beq target"
  };

  tb_clock_gen u_clock_gen (
    .clock   (clock),
    .reset_n (reset_n)
  );

  rv32_dual_top DUT (
    .clock      (clock),
    .reset_n    (reset_n),
    .pc_out     (pc_out),
    .uart_valid (uart_valid),
    .uart_data  (uart_data)
  );

  task automatic check_value(input string name, input logic [xlen-1:0] actual,
                             input logic [xlen-1:0] expected);
    if (actual !== expected) begin
      $display("[FAIL] t=%0t %s: got 0x%0h, expected 0x%0h", $time, name, actual, expected);
      $display("FAIL: see errors above");
      $fatal(1, "Stopped at first mismatch");
    end
  endtask

  // Outputs are sampled on the falling edge, away from the commit edge
  task automatic next_uart_byte(output logic [7:0] value);
    do begin
      @(negedge clock);
    end while (!uart_valid);
    value = uart_data;
  endtask

  initial begin
    logic [7:0] got;
    @(negedge clock);
    while (!reset_n) begin
      check_value("pc_out during reset", pc_out, '0);
      check_value("uart_valid during reset", 32'(uart_valid), '0);
      @(negedge clock);
    end
    // Release edge leaves pc at 0
    check_value("pc_out after reset", pc_out, '0);
    check_value("uart_valid after reset", 32'(uart_valid), '0);

    for (int i = 0; i < num_entries; i++) begin
      next_uart_byte(got);
      check_value($sformatf("uart_data (%s)", exp_origin[i]), 32'(got), 32'(exp_byte[i]));
    end

    repeat (idle_cycles) begin
      @(negedge clock);
      check_value("pc_out at halt", pc_out, halt_pc);
      check_value("uart_valid at halt", 32'(uart_valid), '0);
    end

    $display("PASS: all tests");
    $finish;
  end

  initial begin
    repeat (timeout_cycles) @(posedge clock);
    $display("Watchdog expired after %0d cycles before the UART bytes and halt checks finished",
             timeout_cycles);
    $display("FAIL: see errors above");
    $fatal(1, "Timeout");
  end

endmodule

`default_nettype wire

// ==== sim/tb_clock_gen.sv ====
////////////////////////////////////////////////////////////
// Testbench clock and power-on reset
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
  output logic clock,
  output logic reset_n
);

  localparam int reset_cycles = 8;

  initial begin
    clock = 1'b0;
    forever #5 clock = ~clock;  // 10 ns period
  end

  initial begin
    reset_n = 1'b0;
    repeat (reset_cycles) @(posedge clock);
    reset_n <= 1'b1;            // Released on a rising edge
  end

endmodule

`default_nettype wire

// ==== source/alu.sv ====
////////////////////////////////////////////////////////////
// RV32I arithmetic, logic, compare and shift unit
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module alu import rv32_pkg::*; (
  input  alu_op_e         op,
  input  logic [xlen-1:0] a,
  input  logic [xlen-1:0] b,
  output logic [xlen-1:0] result
);

  logic [4:0] shamt;

  assign shamt = b[4:0];

  always_comb begin
    case (op)
      alu_add:  result = a + b;
      alu_sub:  result = a - b;
      alu_sll:  result = a << shamt;
      alu_slt:  result = {31'b0, $signed(a) < $signed(b)};
      alu_sltu: result = {31'b0, a < b};
      alu_xor:  result = a ^ b;
      alu_srl:  result = a >> shamt;
      alu_sra:  result = $unsigned($signed(a) >>> shamt);  // Sign fill
      alu_or:   result = a | b;
      alu_and:  result = a & b;
      default:  result = '0;
    endcase
  end

endmodule

`default_nettype wire

// ==== source/exec_lane.sv ====
////////////////////////////////////////////////////////////
// One issue slot: decode, execute, branch, write-back select
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module exec_lane import rv32_pkg::*; (
  input  logic [xlen-1:0] slot_word,
  input  logic [xlen-1:0] slot_pc,
  reg_port_if.lane        regs,
  mem_port_if.lane        mem,
  output logic            jump_taken,
  output logic [xlen-1:0] target
);

  opcode_e         op;
  logic [2:0]      funct3;
  logic [xlen-1:0] imm;
  logic [xlen-1:0] alu_a;
  logic [xlen-1:0] alu_b;
  logic [xlen-1:0] alu_result;
  alu_op_e         alu_op;
  wb_sel_e         wb_sel;
  logic            branch_true;
  mem_width_e      width;

  assign op     = opcode_e'(slot_word[6:0]);
  assign funct3 = slot_word[14:12];
  assign width  = mem_width_e'(funct3);

  assign regs.rs1_addr = (op == op_lui) ? '0 : slot_word[19:15];  // LUI adds to zero
  assign regs.rs2_addr = slot_word[24:20];
  assign regs.rd_addr  = slot_word[11:7];
  assign regs.rd_we    = op inside {op_reg, op_imm, op_load, op_lui, op_auipc, op_jal, op_jalr};

  always_comb begin
    case (op)
      op_imm, op_load, op_jalr: imm = {{20{slot_word[31]}}, slot_word[31:20]};
      op_store:  imm = {{20{slot_word[31]}}, slot_word[31:25], slot_word[11:7]};
      op_branch: imm = {{19{slot_word[31]}}, slot_word[31], slot_word[7],
                        slot_word[30:25], slot_word[11:8], 1'b0};
      op_lui, op_auipc: imm = {slot_word[31:12], 12'b0};
      op_jal:    imm = {{11{slot_word[31]}}, slot_word[31], slot_word[19:12],
                        slot_word[20], slot_word[30:21], 1'b0};
      default:   imm = '0;
    endcase
  end

  // Shift-right immediates keep bit 30 for SRAI
  always_comb begin
    case (op)
      op_reg:  alu_op = alu_op_e'({slot_word[30], funct3});
      op_imm:  alu_op = (funct3 == 3'b101) ? alu_op_e'({slot_word[30], funct3})
                                           : alu_op_e'({1'b0, funct3});
      default: alu_op = alu_add;                     // Addresses and targets
    endcase
  end

  assign alu_a = (op inside {op_branch, op_auipc, op_jal}) ? slot_pc : regs.rs1_data;
  assign alu_b = (op == op_reg) ? regs.rs2_data : imm;

  alu u_alu (
    .op     (alu_op),
    .a      (alu_a),
    .b      (alu_b),
    .result (alu_result)
  );

  always_comb begin
    case (funct3)
      3'b000:  branch_true = (regs.rs1_data == regs.rs2_data);
      3'b001:  branch_true = (regs.rs1_data != regs.rs2_data);
      3'b100:  branch_true = ($signed(regs.rs1_data) < $signed(regs.rs2_data));
      3'b101:  branch_true = ($signed(regs.rs1_data) >= $signed(regs.rs2_data));
      3'b110:  branch_true = (regs.rs1_data < regs.rs2_data);
      3'b111:  branch_true = (regs.rs1_data >= regs.rs2_data);
      default: branch_true = 1'b0;
    endcase
  end

  assign jump_taken = (op inside {op_jal, op_jalr}) || ((op == op_branch) && branch_true);
  assign target     = alu_result;

  assign wb_sel = (op == op_load) ? wb_mem :
                  (op inside {op_jal, op_jalr}) ? wb_link : wb_alu;

  always_comb begin
    case (wb_sel)
      wb_mem:  regs.rd_data = mem.load_data;
      wb_link: regs.rd_data = slot_pc + 32'd4;
      default: regs.rd_data = alu_result;
    endcase
  end

  assign mem.addr = (width == mw_word) ? {alu_result[xlen-1:2], 2'b00} :
                    (funct3[1:0] == 2'b01) ? {alu_result[xlen-1:1], 1'b0} : alu_result;
  assign mem.width      = width;
  assign mem.store_en   = (op == op_store);
  assign mem.store_data = regs.rs2_data;

endmodule

`default_nettype wire

// ==== source/fetch_pair.sv ====
////////////////////////////////////////////////////////////
// Program counter, pairing check, slot-2 squash, next PC
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module fetch_pair import rv32_pkg::*; (
  input  logic            clock,
  input  logic            reset_n,
  input  logic [xlen-1:0] fetch_word1,
  input  logic [xlen-1:0] fetch_word2,
  input  logic            jump_taken1,
  input  logic            jump_taken2,
  input  logic [xlen-1:0] target1,
  input  logic [xlen-1:0] target2,
  output logic [xlen-1:0] fetch_pc,
  output logic [xlen-1:0] slot1_word,
  output logic [xlen-1:0] slot2_word,
  output logic [xlen-1:0] slot2_pc
);

  logic [xlen-1:0]       pc;
  logic [xlen-1:0]       next_pc;
  opcode_e               op1;
  opcode_e               op2;
  logic [reg_addr_w-1:0] rd1;
  logic [reg_addr_w-1:0] rs1_2;
  logic [reg_addr_w-1:0] rs2_2;
  logic                  writes_rd1;
  logic                  uses_rs1_2;
  logic                  uses_rs2_2;
  logic                  raw_hazard;
  logic                  jump1;
  logic                  width_clash;
  logic                  pair_ok;
  logic                  branch_taken1;

  // Predecode of both fetched words
  assign op1   = opcode_e'(fetch_word1[6:0]);
  assign op2   = opcode_e'(fetch_word2[6:0]);
  assign rd1   = fetch_word1[11:7];
  assign rs1_2 = fetch_word2[19:15];
  assign rs2_2 = fetch_word2[24:20];

  assign writes_rd1 = (rd1 != '0) &&
                      (op1 inside {op_reg, op_imm, op_load, op_lui, op_auipc, op_jal, op_jalr});
  assign uses_rs1_2 = op2 inside {op_reg, op_imm, op_load, op_store, op_branch, op_jalr};
  assign uses_rs2_2 = op2 inside {op_reg, op_store, op_branch};

  assign raw_hazard = writes_rd1 &&
                      ((uses_rs1_2 && (rs1_2 == rd1)) || (uses_rs2_2 && (rs2_2 == rd1)));
  assign jump1       = op1 inside {op_jal, op_jalr};
  assign width_clash = (op1 == op_store) && (op2 == op_load) &&
                       (mem_width_e'(fetch_word1[14:12]) != mem_width_e'(fetch_word2[14:12]));

  assign pair_ok       = !jump1 && !raw_hazard && !width_clash;
  assign branch_taken1 = (op1 == op_branch) && jump_taken1;

  assign fetch_pc   = pc;
  assign slot1_word = fetch_word1;
  assign slot2_word = (pair_ok && !branch_taken1) ? fetch_word2 : nop_word;  // Squash slot 2
  assign slot2_pc   = pc + 32'd4;

  always_comb begin
    if (jump_taken1) begin
      next_pc = {target1[xlen-1:1], 1'b0};
    end else if (jump_taken2) begin
      next_pc = {target2[xlen-1:1], 1'b0};  // Only reachable when paired
    end else if (pair_ok) begin
      next_pc = pc + 32'd8;
    end else begin
      next_pc = pc + 32'd4;
    end
  end

  always_ff @(posedge clock or negedge reset_n) begin
    if (!reset_n) begin
      pc <= '0;
    end else begin
      pc <= next_pc;
    end
  end

endmodule

`default_nettype wire

// ==== source/lane_ifs.sv ====
////////////////////////////////////////////////////////////
// Per-lane register port and memory port interfaces
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

interface reg_port_if import rv32_pkg::*; ();
  logic [reg_addr_w-1:0] rs1_addr;
  logic [reg_addr_w-1:0] rs2_addr;
  logic [reg_addr_w-1:0] rd_addr;
  logic                  rd_we;
  logic [xlen-1:0]       rd_data;
  logic [xlen-1:0]       rs1_data;  // Combinational read data
  logic [xlen-1:0]       rs2_data;

  modport lane (output rs1_addr, rs2_addr, rd_addr, rd_we, rd_data,
                input  rs1_data, rs2_data);
  modport file (input  rs1_addr, rs2_addr, rd_addr, rd_we, rd_data,
                output rs1_data, rs2_data);
endinterface

interface mem_port_if import rv32_pkg::*; ();
  logic [xlen-1:0] addr;        // Already aligned to width
  mem_width_e      width;
  logic            store_en;
  logic [xlen-1:0] store_data;
  logic [xlen-1:0] load_data;   // Extended per width

  modport lane   (output addr, width, store_en, store_data,
                  input  load_data);
  modport memory (input  addr, width, store_en, store_data,
                  output load_data);
endinterface

`default_nettype wire

// ==== source/register_file.sv ====
////////////////////////////////////////////////////////////
// 31 general registers, four read and two write ports
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module register_file import rv32_pkg::*; (
  input  logic     clock,
  reg_port_if.file lane1,
  reg_port_if.file lane2
);

  logic [xlen-1:0] regs [1:31];  // x0 is not stored

  function automatic logic [xlen-1:0] read_reg(input logic [reg_addr_w-1:0] idx);
    return (idx == '0) ? '0 : regs[idx];
  endfunction

  assign lane1.rs1_data = read_reg(lane1.rs1_addr);
  assign lane1.rs2_data = read_reg(lane1.rs2_addr);
  assign lane2.rs1_data = read_reg(lane2.rs1_addr);
  assign lane2.rs2_data = read_reg(lane2.rs2_addr);

  // Lane 2 is the later instruction so its write lands last
  always_ff @(posedge clock) begin
    if (lane1.rd_we && (lane1.rd_addr != '0)) begin
      regs[lane1.rd_addr] <= lane1.rd_data;
    end
    if (lane2.rd_we && (lane2.rd_addr != '0)) begin
      regs[lane2.rd_addr] <= lane2.rd_data;
    end
  end

endmodule

`default_nettype wire

// ==== source/rv32_dual_top.sv ====
////////////////////////////////////////////////////////////
// Two-wide RV32I core top level
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module rv32_dual_top import rv32_pkg::*; (
  input  logic            clock,
  input  logic            reset_n,
  output logic [xlen-1:0] pc_out,
  output logic            uart_valid,
  output logic [7:0]      uart_data
);

  logic [xlen-1:0] fetch_word1;
  logic [xlen-1:0] fetch_word2;
  logic [xlen-1:0] slot1_word;
  logic [xlen-1:0] slot2_word;
  logic [xlen-1:0] slot2_pc;
  logic            jump_taken1;
  logic            jump_taken2;
  logic [xlen-1:0] target1;
  logic [xlen-1:0] target2;

  reg_port_if rp1 ();
  reg_port_if rp2 ();
  mem_port_if mp1 ();
  mem_port_if mp2 ();

  fetch_pair u_fetch (
    .clock       (clock),
    .reset_n     (reset_n),
    .fetch_word1 (fetch_word1),
    .fetch_word2 (fetch_word2),
    .jump_taken1 (jump_taken1),
    .jump_taken2 (jump_taken2),
    .target1     (target1),
    .target2     (target2),
    .fetch_pc    (pc_out),
    .slot1_word  (slot1_word),
    .slot2_word  (slot2_word),
    .slot2_pc    (slot2_pc)
  );

  exec_lane u_lane1 (
    .slot_word  (slot1_word),
    .slot_pc    (pc_out),        // Slot 1 runs at the fetch pc
    .regs       (rp1),
    .mem        (mp1),
    .jump_taken (jump_taken1),
    .target     (target1)
  );

  exec_lane u_lane2 (
    .slot_word  (slot2_word),
    .slot_pc    (slot2_pc),
    .regs       (rp2),
    .mem        (mp2),
    .jump_taken (jump_taken2),
    .target     (target2)
  );

  register_file u_rf (
    .clock (clock),
    .lane1 (rp1),
    .lane2 (rp2)
  );

  unified_memory u_mem (
    .clock       (clock),
    .reset_n     (reset_n),
    .fetch_pc    (pc_out),
    .fetch_word1 (fetch_word1),
    .fetch_word2 (fetch_word2),
    .lane1       (mp1),
    .lane2       (mp2),
    .uart_valid  (uart_valid),
    .uart_data   (uart_data)
  );

endmodule

`default_nettype wire

// ==== source/rv32_pkg.sv ====
////////////////////////////////////////////////////////////
// Shared widths, opcode classes, ALU controls, access
// widths, write-back sources and the UART address
////////////////////////////////////////////////////////////
`default_nettype none

package rv32_pkg;

  localparam int xlen       = 32;
  localparam int reg_addr_w = 5;
  localparam int mem_bytes  = 65536;
  localparam int mem_addr_w = $clog2(mem_bytes);  // Byte index width

  localparam logic [xlen-1:0] uart_addr = 32'h0000_fff0;
  localparam logic [xlen-1:0] nop_word  = '0;     // Matches no opcode class

  typedef enum logic [6:0] {
    op_reg    = 7'b0110011,
    op_imm    = 7'b0010011,
    op_load   = 7'b0000011,
    op_store  = 7'b0100011,
    op_branch = 7'b1100011,
    op_lui    = 7'b0110111,
    op_auipc  = 7'b0010111,
    op_jal    = 7'b1101111,
    op_jalr   = 7'b1100111
  } opcode_e;

  // Encoded as {instr[30], funct3}
  typedef enum logic [3:0] {
    alu_add  = 4'b0000,
    alu_sub  = 4'b1000,
    alu_sll  = 4'b0001,
    alu_slt  = 4'b0010,
    alu_sltu = 4'b0011,
    alu_xor  = 4'b0100,
    alu_srl  = 4'b0101,
    alu_sra  = 4'b1101,
    alu_or   = 4'b0110,
    alu_and  = 4'b0111
  } alu_op_e;

  typedef enum logic [2:0] {
    mw_byte   = 3'b000,
    mw_half   = 3'b001,
    mw_word   = 3'b010,
    mw_byte_u = 3'b100,
    mw_half_u = 3'b101
  } mem_width_e;

  typedef enum logic [1:0] {
    wb_alu  = 2'b00,
    wb_mem  = 2'b01,
    wb_link = 2'b10
  } wb_sel_e;

endpackage

`default_nettype wire

// ==== source/unified_memory.sv ====
////////////////////////////////////////////////////////////
// 64 KiB byte memory, two-word fetch, pair forwarding, UART
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module unified_memory import rv32_pkg::*; (
  input  logic            clock,
  input  logic            reset_n,
  input  logic [xlen-1:0] fetch_pc,
  output logic [xlen-1:0] fetch_word1,
  output logic [xlen-1:0] fetch_word2,
  mem_port_if.memory      lane1,
  mem_port_if.memory      lane2,
  output logic            uart_valid,
  output logic [7:0]      uart_data
);

  logic [7:0] mem [0:mem_bytes-1];
  logic       forward;

  initial $readmemh("program.hex", mem);

  // Little-endian word starting at any byte, index wraps
  function automatic logic [xlen-1:0] read_bytes(input logic [xlen-1:0] addr);
    logic [mem_addr_w-1:0] a;
    a = addr[mem_addr_w-1:0];
    return {mem[a + mem_addr_w'(3)], mem[a + mem_addr_w'(2)],
            mem[a + mem_addr_w'(1)], mem[a]};
  endfunction

  function automatic logic [xlen-1:0] extend(input logic [xlen-1:0] raw, input mem_width_e w);
    case (w)
      mw_byte:   return {{24{raw[7]}}, raw[7:0]};
      mw_half:   return {{16{raw[15]}}, raw[15:0]};
      mw_word:   return raw;
      mw_byte_u: return {24'b0, raw[7:0]};
      mw_half_u: return {16'b0, raw[15:0]};
      default:   return '0;
    endcase
  endfunction

  function automatic logic [3:0] byte_mask(input mem_width_e w);
    case (w)
      mw_byte: return 4'b0001;
      mw_half: return 4'b0011;
      mw_word: return 4'b1111;
      default: return 4'b0000;  // No store with unsigned widths
    endcase
  endfunction

  assign fetch_word1 = read_bytes(fetch_pc);
  assign fetch_word2 = read_bytes(fetch_pc + 32'd4);

  // Slot 2 sees the slot 1 store it would otherwise miss
  assign forward = lane1.store_en && !lane2.store_en &&
                   (lane1.addr == lane2.addr) && (lane1.width == lane2.width);

  assign lane1.load_data = extend(read_bytes(lane1.addr), lane1.width);
  assign lane2.load_data = forward ? extend(lane1.store_data, lane2.width)
                                   : extend(read_bytes(lane2.addr), lane2.width);

  // Lane 2 is the later store so all of its bytes land last
  always_ff @(posedge clock) begin
    for (int i = 0; i < 4; i++) begin
      if (lane1.store_en && byte_mask(lane1.width)[i]) begin
        mem[lane1.addr[mem_addr_w-1:0] + mem_addr_w'(i)] <= lane1.store_data[8*i +: 8];
      end
    end
    for (int i = 0; i < 4; i++) begin
      if (lane2.store_en && byte_mask(lane2.width)[i]) begin
        mem[lane2.addr[mem_addr_w-1:0] + mem_addr_w'(i)] <= lane2.store_data[8*i +: 8];
      end
    end
  end

  always_ff @(posedge clock or negedge reset_n) begin
    if (!reset_n) begin
      uart_valid <= 1'b0;
      uart_data  <= '0;
    end else if (lane1.store_en && (lane1.addr == uart_addr)) begin
      uart_valid <= 1'b1;                       // Lane 1 wins a double store
      uart_data  <= lane1.store_data[7:0];
    end else if (lane2.store_en && (lane2.addr == uart_addr)) begin
      uart_valid <= 1'b1;
      uart_data  <= lane2.store_data[7:0];
    end else begin
      uart_valid <= 1'b0;                       // One-cycle strobe
    end
  end

endmodule

`default_nettype wire
